// File: hdl/i2s_cfg_pkg.sv
////////////////////////////////////////////////////////////
// Widths, register map and field positions shared by the
// stages of the I2S configuration block
////////////////////////////////////////////////////////////

`default_nettype none

package i2s_cfg_pkg;

    localparam int CFG_DATA_W  = 32;
    localparam int CFG_ADDR_W  = 5;
    localparam int DIV_W       = 8;
    localparam int BITS_WORD_W = 5;
    localparam int WORDS_W     = 3;
    localparam int DS_W        = 2;

    // Word offsets on the config bus
    typedef enum logic [CFG_ADDR_W-1:0] {
        REG_RX_SADDR  = 5'd0,
        REG_RX_SIZE   = 5'd1,
        REG_RX_CFG    = 5'd2,
        REG_CLKCFG    = 5'd8,
        REG_SLV_SETUP = 5'd9,
        REG_NONE      = 5'd31   // Anything unmapped
    } reg_addr_e;

    typedef enum logic [DS_W-1:0] {
        DS_BYTE = 2'd0,
        DS_HALF = 2'd1,
        DS_WORD = 2'd2
    } datasize_e;

    ////////////////////////////////////////////////////////////
    // Field positions
    ////////////////////////////////////////////////////////////

    // REG_RX_CFG
    localparam int RX_CFG_CLR_BIT  = 5;
    localparam int RX_CFG_PEND_BIT = 5;   // Read side
    localparam int RX_CFG_EN_BIT   = 4;
    localparam int RX_CFG_DS_LSB   = 1;
    localparam int RX_CFG_CONT_BIT = 0;

    // REG_CLKCFG, slave side only
    localparam int CLK_SEL_NUM_BIT    = 29;
    localparam int CLK_SEL_EXT_BIT    = 28;
    localparam int CLK_SLV_EN_BIT     = 24;
    localparam int CLK_COMMON_DIV_LSB = 16;
    localparam int CLK_SLAVE_DIV_LSB  = 8;

    // REG_SLV_SETUP
    localparam int SLV_EN_BIT        = 31;
    localparam int SLV_2CH_BIT       = 17;
    localparam int SLV_LSB_FIRST_BIT = 16;
    localparam int SLV_BITS_WORD_LSB = 8;
    localparam int SLV_WORDS_LSB     = 0;

endpackage

`default_nettype wire

// File: hdl/cfg_req_if.sv
////////////////////////////////////////////////////////////
// One decoded bus request, decode stage to register stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface cfg_req_if;

    logic                               req_valid;   // Single-cycle strobe
    logic                               req_write;
    i2s_cfg_pkg::reg_addr_e             req_addr;
    logic [i2s_cfg_pkg::CFG_DATA_W-1:0] req_wdata;

    modport src (
        output req_valid,
        output req_write,
        output req_addr,
        output req_wdata
    );

    modport dst (
        input  req_valid,
        input  req_write,
        input  req_addr,
        input  req_wdata
    );

endinterface

`default_nettype wire

// File: hdl/clk_setup_if.sv
////////////////////////////////////////////////////////////
// Clock-setup fields in the clk_i domain plus the strobe
// that announces a new value to the sync stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface clk_setup_if;

    logic                          upd;   // One cycle after a CLKCFG write
    logic                          sel_num;
    logic                          sel_ext;
    logic                          clk_en;
    logic [i2s_cfg_pkg::DIV_W-1:0] common_div;
    logic [i2s_cfg_pkg::DIV_W-1:0] slave_div;

    modport src (
        output upd,
        output sel_num,
        output sel_ext,
        output clk_en,
        output common_div,
        output slave_div
    );

    modport dst (
        input  upd,
        input  sel_num,
        input  sel_ext,
        input  clk_en,
        input  common_div,
        input  slave_div
    );

endinterface

`default_nettype wire

// File: hdl/cfg_req_decode.sv
////////////////////////////////////////////////////////////
// First stage, registers the config bus request and maps
// the raw word offset onto the register enum
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cfg_req_decode (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               cfg_valid_i,
    input  logic                               cfg_rwn_i,
    input  logic [i2s_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [i2s_cfg_pkg::CFG_DATA_W-1:0] cfg_data_i,
    cfg_req_if.src                             req
);

    i2s_cfg_pkg::reg_addr_e addr_dec;

    always_comb
    begin
        case (cfg_addr_i)
            i2s_cfg_pkg::REG_RX_SADDR,
            i2s_cfg_pkg::REG_RX_SIZE,
            i2s_cfg_pkg::REG_RX_CFG,
            i2s_cfg_pkg::REG_CLKCFG,
            i2s_cfg_pkg::REG_SLV_SETUP:
                addr_dec = i2s_cfg_pkg::reg_addr_e'(cfg_addr_i);
            default:
                addr_dec = i2s_cfg_pkg::REG_NONE;   // TX, master and PDM land here too
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            req.req_valid <= 1'b0;
        else
            req.req_valid <= cfg_valid_i;
    end

    // Request payload, only loaded with a strobe
    always_ff @(posedge clk_i)
    begin
        if (cfg_valid_i)
        begin
            req.req_write <= ~cfg_rwn_i;
            req.req_addr  <= addr_dec;
            req.req_wdata <= cfg_data_i;
        end
    end

    // The register stage must never see an unknown offset with a live request
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        req.req_valid |-> !$isunknown(req.req_addr));

endmodule

`default_nettype wire

// File: hdl/i2s_cfg_regs.sv
////////////////////////////////////////////////////////////
// Second stage, register bank with write decode, RX pulses
// and the registered read return
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module i2s_cfg_regs #(
    parameter int L2_AWIDTH  = 12,
    parameter int TRANS_SIZE = 16
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    cfg_req_if.dst                              req,
    clk_setup_if.src                            clk,

    output logic [L2_AWIDTH-1:0]                cfg_rx_startaddr_o,
    output logic [TRANS_SIZE-1:0]               cfg_rx_size_o,
    output i2s_cfg_pkg::datasize_e              cfg_rx_datasize_o,
    output logic                                cfg_rx_continuous_o,
    output logic                                cfg_rx_en_o,
    output logic                                cfg_rx_clr_o,
    input  logic                                cfg_rx_en_i,
    input  logic                                cfg_rx_pending_i,
    input  logic [L2_AWIDTH-1:0]                cfg_rx_curr_addr_i,
    input  logic [TRANS_SIZE-1:0]               cfg_rx_bytes_left_i,

    output logic                                cfg_slave_i2s_en_o,
    output logic                                cfg_slave_i2s_lsb_first_o,
    output logic                                cfg_slave_i2s_2ch_o,
    output logic [i2s_cfg_pkg::BITS_WORD_W-1:0] cfg_slave_i2s_bits_word_o,
    output logic [i2s_cfg_pkg::WORDS_W-1:0]     cfg_slave_i2s_words_o,

    output logic [i2s_cfg_pkg::CFG_DATA_W-1:0]  cfg_rdata_o,
    output logic                                cfg_rvalid_o
);

    logic                               wr_en;
    logic                               rd_en;
    logic [i2s_cfg_pkg::CFG_DATA_W-1:0] rdata_d;
    logic [i2s_cfg_pkg::CFG_DATA_W-1:0] wdata;

    logic r_rx_en;
    logic r_rx_clr;
    logic r_upd;
    logic r_rvalid;
    logic [i2s_cfg_pkg::CFG_DATA_W-1:0] r_rdata;

    assign wr_en = req.req_valid & req.req_write;
    assign rd_en = req.req_valid & ~req.req_write;
    assign wdata = req.req_wdata;

    ////////////////////////////////////////////////////////////
    // Register bank
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cfg_rx_startaddr_o        <= '0;
            cfg_rx_size_o             <= '0;
            cfg_rx_datasize_o         <= i2s_cfg_pkg::DS_WORD;
            cfg_rx_continuous_o       <= 1'b0;
            r_rx_en                   <= 1'b0;
            r_rx_clr                  <= 1'b0;
            r_upd                     <= 1'b0;
            clk.sel_num               <= 1'b0;
            clk.sel_ext               <= 1'b0;
            clk.clk_en                <= 1'b0;
            clk.common_div            <= '0;
            clk.slave_div             <= '0;
            cfg_slave_i2s_en_o        <= 1'b0;
            cfg_slave_i2s_2ch_o       <= 1'b0;
            cfg_slave_i2s_lsb_first_o <= 1'b0;
            cfg_slave_i2s_bits_word_o <= '0;
            cfg_slave_i2s_words_o     <= '0;
        end
        else
        begin
            r_rx_en  <= 1'b0;
            r_rx_clr <= 1'b0;
            r_upd    <= wr_en && (req.req_addr == i2s_cfg_pkg::REG_CLKCFG);
            if (wr_en)
            begin
                case (req.req_addr)
                    i2s_cfg_pkg::REG_RX_SADDR:
                        cfg_rx_startaddr_o <= wdata[L2_AWIDTH-1:0];
                    i2s_cfg_pkg::REG_RX_SIZE:
                        cfg_rx_size_o <= wdata[TRANS_SIZE-1:0];
                    i2s_cfg_pkg::REG_RX_CFG:
                    begin
                        r_rx_clr            <= wdata[i2s_cfg_pkg::RX_CFG_CLR_BIT];
                        r_rx_en             <= wdata[i2s_cfg_pkg::RX_CFG_EN_BIT];
                        cfg_rx_datasize_o   <= i2s_cfg_pkg::datasize_e'(
                            wdata[i2s_cfg_pkg::RX_CFG_DS_LSB +: i2s_cfg_pkg::DS_W]);
                        cfg_rx_continuous_o <= wdata[i2s_cfg_pkg::RX_CFG_CONT_BIT];
                    end
                    i2s_cfg_pkg::REG_CLKCFG:
                    begin
                        clk.sel_num    <= wdata[i2s_cfg_pkg::CLK_SEL_NUM_BIT];
                        clk.sel_ext    <= wdata[i2s_cfg_pkg::CLK_SEL_EXT_BIT];
                        clk.clk_en     <= wdata[i2s_cfg_pkg::CLK_SLV_EN_BIT];
                        clk.common_div <=
                            wdata[i2s_cfg_pkg::CLK_COMMON_DIV_LSB +: i2s_cfg_pkg::DIV_W];
                        clk.slave_div  <=
                            wdata[i2s_cfg_pkg::CLK_SLAVE_DIV_LSB +: i2s_cfg_pkg::DIV_W];
                    end
                    i2s_cfg_pkg::REG_SLV_SETUP:
                    begin
                        if (!clk.clk_en)   // Locked while the slave clock runs
                        begin
                            cfg_slave_i2s_en_o        <= wdata[i2s_cfg_pkg::SLV_EN_BIT];
                            cfg_slave_i2s_2ch_o       <= wdata[i2s_cfg_pkg::SLV_2CH_BIT];
                            cfg_slave_i2s_lsb_first_o <= wdata[i2s_cfg_pkg::SLV_LSB_FIRST_BIT];
                            cfg_slave_i2s_bits_word_o <= wdata[i2s_cfg_pkg::SLV_BITS_WORD_LSB
                                                         +: i2s_cfg_pkg::BITS_WORD_W];
                            cfg_slave_i2s_words_o     <= wdata[i2s_cfg_pkg::SLV_WORDS_LSB
                                                         +: i2s_cfg_pkg::WORDS_W];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cfg_rx_en_o  = r_rx_en;
    assign cfg_rx_clr_o = r_rx_clr;
    assign clk.upd      = r_upd;

    ////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        rdata_d = '0;
        case (req.req_addr)
            i2s_cfg_pkg::REG_RX_SADDR:
                rdata_d[L2_AWIDTH-1:0] = cfg_rx_curr_addr_i;     // Live channel status
            i2s_cfg_pkg::REG_RX_SIZE:
                rdata_d[TRANS_SIZE-1:0] = cfg_rx_bytes_left_i;
            i2s_cfg_pkg::REG_RX_CFG:
            begin
                rdata_d[i2s_cfg_pkg::RX_CFG_PEND_BIT] = cfg_rx_pending_i;
                rdata_d[i2s_cfg_pkg::RX_CFG_EN_BIT]   = cfg_rx_en_i;
                rdata_d[i2s_cfg_pkg::RX_CFG_DS_LSB +: i2s_cfg_pkg::DS_W] = cfg_rx_datasize_o;
                rdata_d[i2s_cfg_pkg::RX_CFG_CONT_BIT] = cfg_rx_continuous_o;
            end
            i2s_cfg_pkg::REG_CLKCFG:
            begin
                rdata_d[i2s_cfg_pkg::CLK_SEL_NUM_BIT] = clk.sel_num;
                rdata_d[i2s_cfg_pkg::CLK_SEL_EXT_BIT] = clk.sel_ext;
                rdata_d[i2s_cfg_pkg::CLK_SLV_EN_BIT]  = clk.clk_en;
                rdata_d[i2s_cfg_pkg::CLK_COMMON_DIV_LSB +: i2s_cfg_pkg::DIV_W] = clk.common_div;
                rdata_d[i2s_cfg_pkg::CLK_SLAVE_DIV_LSB +: i2s_cfg_pkg::DIV_W]  = clk.slave_div;
            end
            i2s_cfg_pkg::REG_SLV_SETUP:
            begin
                rdata_d[i2s_cfg_pkg::SLV_EN_BIT]        = cfg_slave_i2s_en_o;
                rdata_d[i2s_cfg_pkg::SLV_2CH_BIT]       = cfg_slave_i2s_2ch_o;
                rdata_d[i2s_cfg_pkg::SLV_LSB_FIRST_BIT] = cfg_slave_i2s_lsb_first_o;
                rdata_d[i2s_cfg_pkg::SLV_BITS_WORD_LSB +: i2s_cfg_pkg::BITS_WORD_W] =
                    cfg_slave_i2s_bits_word_o;
                rdata_d[i2s_cfg_pkg::SLV_WORDS_LSB +: i2s_cfg_pkg::WORDS_W] =
                    cfg_slave_i2s_words_o;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            r_rvalid <= 1'b0;
        else
            r_rvalid <= rd_en;
    end

    always_ff @(posedge clk_i)
    begin
        if (rd_en)
            r_rdata <= rdata_d;
    end

    assign cfg_rdata_o  = r_rdata;
    assign cfg_rvalid_o = r_rvalid;

    // An RX pulse only stays high when a new request retriggers it
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_rx_en_o |=> !cfg_rx_en_o || $past(req.req_valid));

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_rx_clr_o |=> !cfg_rx_clr_o || $past(req.req_valid));

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_rvalid_o |-> $past(rd_en));

endmodule

`default_nettype wire

// File: hdl/clk_cfg_sync.sv
////////////////////////////////////////////////////////////
// Third stage, carries clock-setup updates into the
// peripheral clock domain through a toggle synchronizer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clk_cfg_sync (
    input  logic                            clk_i,
    input  logic                            periph_clk_i,
    input  logic                            rstn_i,
    clk_setup_if.dst                        clk,
    output logic                            cfg_slave_sel_num_o,
    output logic                            cfg_slave_sel_ext_o,
    output logic                            cfg_slave_clk_en_o,
    output logic [2*i2s_cfg_pkg::DIV_W-1:0] cfg_slave_gen_clk_div_o
);

    logic       upd_toggle;
    logic [2:0] sync_q;      // Two sync flops, then history
    logic       load;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            upd_toggle <= 1'b0;
        else if (clk.upd)
            upd_toggle <= ~upd_toggle;
    end

    ////////////////////////////////////////////////////////////
    // Peripheral domain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge periph_clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            sync_q <= '0;
        else
            sync_q <= {sync_q[1:0], upd_toggle};
    end

    assign load = sync_q[2] ^ sync_q[1];

    // Fields are stable in clk_i by the time the toggle arrives
    always_ff @(posedge periph_clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cfg_slave_sel_num_o     <= 1'b0;
            cfg_slave_sel_ext_o     <= 1'b0;
            cfg_slave_clk_en_o      <= 1'b0;
            cfg_slave_gen_clk_div_o <= '0;
        end
        else if (load)
        begin
            cfg_slave_sel_num_o     <= clk.sel_num;
            cfg_slave_sel_ext_o     <= clk.sel_ext;
            cfg_slave_clk_en_o      <= clk.clk_en;
            cfg_slave_gen_clk_div_o <= {clk.common_div, clk.slave_div};
        end
    end

    // Back-to-back strobes would cancel out in the toggle
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        clk.upd |=> !clk.upd);

endmodule

`default_nettype wire

// File: hdl/udma_i2s_cfg_top.sv
////////////////////////////////////////////////////////////
// uDMA I2S configuration block, decode, register and
// clock-domain stages behind plain bus ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module udma_i2s_cfg_top #(
    parameter int L2_AWIDTH  = 12,
    parameter int TRANS_SIZE = 16
) (
    input  logic                                clk_i,
    input  logic                                periph_clk_i,
    input  logic                                rstn_i,

    // Config bus, read data two cycles after the request
    input  logic [i2s_cfg_pkg::CFG_DATA_W-1:0]  cfg_data_i,
    input  logic [i2s_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr_i,
    input  logic                                cfg_valid_i,
    input  logic                                cfg_rwn_i,
    output logic [i2s_cfg_pkg::CFG_DATA_W-1:0]  cfg_rdata_o,
    output logic                                cfg_rvalid_o,

    output logic [L2_AWIDTH-1:0]                cfg_rx_startaddr_o,
    output logic [TRANS_SIZE-1:0]               cfg_rx_size_o,
    output i2s_cfg_pkg::datasize_e              cfg_rx_datasize_o,
    output logic                                cfg_rx_continuous_o,
    output logic                                cfg_rx_en_o,
    output logic                                cfg_rx_clr_o,
    input  logic                                cfg_rx_en_i,
    input  logic                                cfg_rx_pending_i,
    input  logic [L2_AWIDTH-1:0]                cfg_rx_curr_addr_i,
    input  logic [TRANS_SIZE-1:0]               cfg_rx_bytes_left_i,

    output logic                                cfg_slave_i2s_en_o,
    output logic                                cfg_slave_i2s_lsb_first_o,
    output logic                                cfg_slave_i2s_2ch_o,
    output logic [i2s_cfg_pkg::BITS_WORD_W-1:0] cfg_slave_i2s_bits_word_o,
    output logic [i2s_cfg_pkg::WORDS_W-1:0]     cfg_slave_i2s_words_o,

    // Peripheral clock domain
    output logic                                cfg_slave_sel_num_o,
    output logic                                cfg_slave_sel_ext_o,
    output logic                                cfg_slave_clk_en_o,
    output logic [2*i2s_cfg_pkg::DIV_W-1:0]     cfg_slave_gen_clk_div_o
);

    cfg_req_if   req_if ();
    clk_setup_if clk_if ();

    cfg_req_decode decode_i (
        .req (req_if.src),
        .*
    );

    i2s_cfg_regs #(
        .L2_AWIDTH  (L2_AWIDTH),
        .TRANS_SIZE (TRANS_SIZE)
    ) regs_i (
        .req (req_if.dst),
        .clk (clk_if.src),
        .*
    );

    clk_cfg_sync sync_i (
        .clk (clk_if.dst),
        .*
    );

endmodule

`default_nettype wire

// File: verification/tb_udma_i2s_cfg.sv
////////////////////////////////////////////////////////////
// Testbench for the I2S configuration block. A register
// model predicts every output and assertions compare them
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_udma_i2s_cfg;

    localparam int L2_AWIDTH      = 12;
    localparam int TRANS_SIZE     = 16;
    localparam int TIMEOUT_CYCLES = 2000;   // About five times the full sequence

    logic                   clk_i        = 1'b0;
    logic                   periph_clk_i = 1'b0;
    logic                   rstn_i;
    logic [31:0]            cfg_data_i;
    logic [4:0]             cfg_addr_i;
    logic                   cfg_valid_i;
    logic                   cfg_rwn_i;
    logic [31:0]            cfg_rdata_o;
    logic                   cfg_rvalid_o;
    logic [L2_AWIDTH-1:0]   cfg_rx_startaddr_o;
    logic [TRANS_SIZE-1:0]  cfg_rx_size_o;
    i2s_cfg_pkg::datasize_e cfg_rx_datasize_o;
    logic                   cfg_rx_continuous_o;
    logic                   cfg_rx_en_o;
    logic                   cfg_rx_clr_o;
    logic                   cfg_rx_en_i;
    logic                   cfg_rx_pending_i;
    logic [L2_AWIDTH-1:0]   cfg_rx_curr_addr_i;
    logic [TRANS_SIZE-1:0]  cfg_rx_bytes_left_i;
    logic                   cfg_slave_i2s_en_o;
    logic                   cfg_slave_i2s_lsb_first_o;
    logic                   cfg_slave_i2s_2ch_o;
    logic [4:0]             cfg_slave_i2s_bits_word_o;
    logic [2:0]             cfg_slave_i2s_words_o;
    logic                   cfg_slave_sel_num_o;
    logic                   cfg_slave_sel_ext_o;
    logic                   cfg_slave_clk_en_o;
    logic [15:0]            cfg_slave_gen_clk_div_o;

    // Reference model state
    logic                   s1_valid;
    logic                   s1_write;
    logic [4:0]             s1_addr;
    logic [31:0]            s1_data;
    logic                   exp_rvalid;
    logic [31:0]            exp_rdata;
    logic                   exp_rx_en;
    logic                   exp_rx_clr;
    logic [L2_AWIDTH-1:0]   exp_startaddr;
    logic [TRANS_SIZE-1:0]  exp_size;
    logic [1:0]             exp_datasize;
    logic                   exp_cont;
    logic [2:0]             exp_sel;       // sel_num, sel_ext, clk_en
    logic [15:0]            exp_div;       // Common byte above slave byte
    logic [10:0]            exp_slv;       // en, 2ch, lsb_first, bits_word, words
    logic                   exp_clk_tog;
    logic                   seen_tog;
    logic [3:0]             settle_cnt;
    logic [10:0]            slv_out;
    logic [2:0]             sel_out;
    logic [4:0]             hot_addr [4] = '{5'd0, 5'd1, 5'd2, 5'd9};
    int                     clk_errors    = 0;
    int                     periph_errors = 0;
    int                     reads_seen    = 0;
    int                     cycles        = 0;
    integer                 seed          = 32'hd2f3_fa2c;

    assign slv_out = {cfg_slave_i2s_en_o, cfg_slave_i2s_2ch_o, cfg_slave_i2s_lsb_first_o,
                      cfg_slave_i2s_bits_word_o, cfg_slave_i2s_words_o};
    assign sel_out = {cfg_slave_sel_num_o, cfg_slave_sel_ext_o, cfg_slave_clk_en_o};

    udma_i2s_cfg_top #(
        .L2_AWIDTH  (L2_AWIDTH),
        .TRANS_SIZE (TRANS_SIZE)
    ) dut_i (.*);

    always #4 clk_i = ~clk_i;
    always #10 periph_clk_i = ~periph_clk_i;

    function automatic int report_mismatch(input string name, input logic [31:0] got,
                                           input logic [31:0] want);
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
        return 1;
    endfunction

    // Register word as the map defines it, status bits taken live
    function automatic logic [31:0] read_word(input logic [4:0] addr);
        logic [31:0] w;
        w = '0;
        case (addr)
            5'd0: w[L2_AWIDTH-1:0] = cfg_rx_curr_addr_i;
            5'd1: w[TRANS_SIZE-1:0] = cfg_rx_bytes_left_i;
            5'd2: w[5:0] = {cfg_rx_pending_i, cfg_rx_en_i, 1'b0, exp_datasize, exp_cont};
            5'd8: w = {2'b00, exp_sel[2:1], 3'b000, exp_sel[0], exp_div, 8'h00};
            5'd9: w = {exp_slv[10], 13'd0, exp_slv[9:8], 3'd0, exp_slv[7:3], 5'd0, exp_slv[2:0]};
            default: ;
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // Model, request taken at one edge and executed at the next
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            s1_valid      <= 1'b0;
            exp_rvalid    <= 1'b0;
            exp_rx_en     <= 1'b0;
            exp_rx_clr    <= 1'b0;
            exp_startaddr <= '0;
            exp_size      <= '0;
            exp_datasize  <= 2'd2;   // Word
            exp_cont      <= 1'b0;
            exp_sel       <= '0;
            exp_div       <= '0;
            exp_slv       <= '0;
            exp_clk_tog   <= 1'b0;
        end
        else
        begin
            s1_valid   <= cfg_valid_i;
            s1_write   <= ~cfg_rwn_i;
            s1_addr    <= cfg_addr_i;
            s1_data    <= cfg_data_i;
            exp_rvalid <= s1_valid && !s1_write;
            exp_rx_en  <= 1'b0;
            exp_rx_clr <= 1'b0;
            if (s1_valid && !s1_write)
                exp_rdata <= read_word(s1_addr);
            if (s1_valid && s1_write)
            begin
                case (s1_addr)
                    5'd0: exp_startaddr <= s1_data[L2_AWIDTH-1:0];
                    5'd1: exp_size <= s1_data[TRANS_SIZE-1:0];
                    5'd2:
                    begin
                        exp_rx_clr   <= s1_data[5];
                        exp_rx_en    <= s1_data[4];
                        exp_datasize <= s1_data[2:1];
                        exp_cont     <= s1_data[0];
                    end
                    5'd8:
                    begin
                        exp_sel     <= {s1_data[29], s1_data[28], s1_data[24]};
                        exp_div     <= s1_data[23:8];
                        exp_clk_tog <= ~exp_clk_tog;   // Marks a new clock setup
                    end
                    5'd9:
                        if (!exp_sel[0])
                            exp_slv <= {s1_data[31], s1_data[17:16], s1_data[12:8], s1_data[2:0]};
                    default: ;
                endcase
            end
        end
    end

    // Periph edges since the last clock setup change
    always @(posedge periph_clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            seen_tog   <= 1'b0;
            settle_cnt <= 4'd15;
        end
        else if (seen_tog != exp_clk_tog)
        begin
            seen_tog   <= exp_clk_tog;
            settle_cnt <= 4'd0;
        end
        else if (settle_cnt != 4'd15)
            settle_cnt <= settle_cnt + 4'd1;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rvalid_o == exp_rvalid)
        else clk_errors += report_mismatch("cfg_rvalid_o",
            32'($sampled(cfg_rvalid_o)), 32'($sampled(exp_rvalid)));
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_rvalid_o |-> cfg_rdata_o == exp_rdata)
        else clk_errors += report_mismatch("cfg_rdata_o",
            $sampled(cfg_rdata_o), $sampled(exp_rdata));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_en_o == exp_rx_en)
        else clk_errors += report_mismatch("cfg_rx_en_o",
            32'($sampled(cfg_rx_en_o)), 32'($sampled(exp_rx_en)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_clr_o == exp_rx_clr)
        else clk_errors += report_mismatch("cfg_rx_clr_o",
            32'($sampled(cfg_rx_clr_o)), 32'($sampled(exp_rx_clr)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_startaddr_o == exp_startaddr)
        else clk_errors += report_mismatch("cfg_rx_startaddr_o",
            32'($sampled(cfg_rx_startaddr_o)), 32'($sampled(exp_startaddr)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_size_o == exp_size)
        else clk_errors += report_mismatch("cfg_rx_size_o",
            32'($sampled(cfg_rx_size_o)), 32'($sampled(exp_size)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_datasize_o == exp_datasize)
        else clk_errors += report_mismatch("cfg_rx_datasize_o",
            32'($sampled(cfg_rx_datasize_o)), 32'($sampled(exp_datasize)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) cfg_rx_continuous_o == exp_cont)
        else clk_errors += report_mismatch("cfg_rx_continuous_o",
            32'($sampled(cfg_rx_continuous_o)), 32'($sampled(exp_cont)));
    assert property (@(posedge clk_i) disable iff (!rstn_i) slv_out == exp_slv)
        else clk_errors += report_mismatch("cfg_slave_i2s_{en,2ch,lsb_first,bits_word,words}_o",
            32'($sampled(slv_out)), 32'($sampled(exp_slv)));

    // Peripheral side must have caught up four edges after a change
    assert property (@(posedge periph_clk_i) disable iff (!rstn_i)
        (settle_cnt >= 4'd3 && seen_tog == exp_clk_tog) |-> sel_out == exp_sel)
        else periph_errors += report_mismatch("cfg_slave_{sel_num,sel_ext,clk_en}_o",
            32'($sampled(sel_out)), 32'($sampled(exp_sel)));
    assert property (@(posedge periph_clk_i) disable iff (!rstn_i)
        (settle_cnt >= 4'd3 && seen_tog == exp_clk_tog) |-> cfg_slave_gen_clk_div_o == exp_div)
        else periph_errors += report_mismatch("cfg_slave_gen_clk_div_o",
            32'($sampled(cfg_slave_gen_clk_div_o)), 32'($sampled(exp_div)));

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cfg_rvalid_o)
            reads_seen <= reads_seen + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("Timeout: sequence still running after %0d clk_i cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_status();
        logic [31:0] rnd;
        rnd = $random(seed);
        cfg_rx_en_i         = rnd[31];
        cfg_rx_pending_i    = rnd[30];
        cfg_rx_curr_addr_i  = rnd[L2_AWIDTH-1:0];
        rnd = $random(seed);
        cfg_rx_bytes_left_i = rnd[TRANS_SIZE-1:0];
    endtask

    // One request cycle, back to back when called in a row
    task automatic send(input logic write, input logic [4:0] addr, input logic [31:0] data);
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = ~write;
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        drive_status();
        @(posedge clk_i);
        #1;
        cfg_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            drive_status();
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic wait_periph(input int n);
        repeat (n) @(posedge periph_clk_i);
        @(posedge clk_i);
        #1;
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [4:0]  addr;
        logic        wr;
        int          a;
        rstn_i      = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b1;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        drive_status();
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        idle(2);
        send(1'b0, 5'd2, '0);                 // Datasize word after reset
        idle(2);
        send(1'b1, 5'd0, 32'h0000_0a5c);
        send(1'b1, 5'd1, 32'h0000_1234);
        send(1'b0, 5'd0, '0);
        send(1'b0, 5'd1, '0);
        idle(2);
        send(1'b1, 5'd2, 32'h0000_0033);      // Clear, enable, half, continuous
        idle(2);
        send(1'b0, 5'd2, '0);
        // Clock setup with dropped positions set
        send(1'b1, 5'd8, 32'hf2a5_3cff);
        send(1'b0, 5'd8, '0);
        wait_periph(8);
        // Slave setup lock
        send(1'b1, 5'd9, 32'h8001_0a05);
        send(1'b0, 5'd9, '0);
        send(1'b1, 5'd8, 32'h3101_2040);
        send(1'b1, 5'd9, 32'h0002_1f02);
        send(1'b0, 5'd9, '0);
        wait_periph(8);
        send(1'b1, 5'd8, 32'h0004_0800);      // Slave clock off again
        wait_periph(8);
        for (a = 0; a < 32; a++)
        begin
            if (a > 2 && a != 8 && a != 9)
            begin
                rnd = $random(seed);
                send(1'b1, 5'(a), rnd);
                send(1'b0, 5'(a), '0);
            end
        end
        repeat (200)
        begin
            rnd  = $random(seed);
            addr = rnd[7] ? rnd[4:0] : hot_addr[rnd[9:8]];
            wr   = rnd[5] && (addr != 5'd8);   // CLKCFG writes need spacing
            send(wr, addr, $random(seed));
        end
        idle(4);
        $display("Done: %0d clk_i error(s), %0d periph_clk_i error(s), %0d read(s) returned",
                 clk_errors, periph_errors, reads_seen);
        if (clk_errors + periph_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/i2s_cfg_pkg.sv
hdl/cfg_req_if.sv
hdl/clk_setup_if.sv
hdl/cfg_req_decode.sv
hdl/i2s_cfg_regs.sv
hdl/clk_cfg_sync.sv
hdl/udma_i2s_cfg_top.sv
verification/tb_udma_i2s_cfg.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_udma_i2s_cfg \
    -f project.f

out=$(./obj_dir/Vtb_udma_i2s_cfg)
echo "$out"
if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
